//--- pdp8_testdata.txt
# Columns: M addr data preloads memory, W addr data is the next expected write
# E acc link pc is the state after HLT; all numbers are octal
# Page zero constants and the ISZ counter
M 0020 7777
M 0021 0001
M 0022 0770
M 0023 0707
M 0024 7776
# TAD carry into the link, AND mask, DCA store
M 0200 1020
M 0201 1021
M 0202 1022
M 0203 0023
M 0204 3040
# ISZ without and with skip
M 0205 2024
M 0206 2024
M 0207 3041
M 0210 4270
# Group 1 micro-ops
M 0211 7300
M 0212 7041
M 0213 7001
M 0214 7004
M 0215 7006
M 0216 7020
M 0217 7010
M 0220 3043
M 0221 7121
M 0222 7012
M 0223 3044
# Group 2 skips, each HLT here is jumped over
M 0224 7440
M 0225 7402
M 0226 7040
M 0227 7500
M 0230 7402
M 0231 7420
M 0232 3045
M 0233 7450
M 0234 7430
M 0235 7402
M 0236 7001
M 0237 7510
M 0240 7402
M 0241 7040
M 0242 7700
M 0243 7402
M 0244 7440
M 0245 7402
M 0246 7020
M 0247 7420
M 0250 7402
M 0251 1023
M 0252 7402
# Subroutine, entered by JMS and left by JMP
M 0270 0000
M 0271 1021
M 0272 3042
M 0273 5211
W 0040 0700
W 0024 7777
W 0024 0000
W 0270 0211
W 0042 0001
W 0043 4006
W 0044 6000
W 0045 7777
E 0707 1 0253

//--- project.f
+incdir+.
pdp8_pkg.sv
pdp8_alu.sv
pdp8_operate.sv
pdp8_sequencer.sv
pdp8_core.sv
pdp8_assertions.sv
pdp8_tb.sv

//--- Makefile
# Verilator simulation of the PDP-8 core testbench

VERILATOR ?= verilator
TOP       ?= pdp8_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q ">>> PASS" $(LOG); then echo "Simulation ended early, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- pdp8_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the PDP-8 core that runs the program and checks in pdp8_testdata.txt
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "pdp8_settings.svh"

module pdp8_tb;

    localparam int resetCycles  = 16;
    localparam int fetchTimeout = 10;
    localparam int haltTimeout  = 2000;
    localparam int quietCycles  = 20;

    logic              clk;
    logic              reset_n;
    pdp8_pkg::dataWord memReadData = '0;
    logic              memRead;
    logic              memWrite;
    pdp8_pkg::addrWord memAddr;
    pdp8_pkg::dataWord memWriteData;
    pdp8_pkg::dataWord acc;
    logic              link;
    pdp8_pkg::addrWord pc;
    logic              halted;

    // Memory image and expected results from the data file
    pdp8_pkg::dataWord mem [0:(1 << `ADDR_WIDTH)-1];
    pdp8_pkg::addrWord expAddr [$];
    pdp8_pkg::dataWord expData [$];
    pdp8_pkg::dataWord finalAcc;
    logic              finalLink;
    pdp8_pkg::addrWord finalPc;
    logic              haveFinal = 1'b0;
    int                writeCount = 0;

    pdp8_core dut (
        .clk          (clk),
        .reset_n      (reset_n),
        .memReadData  (memReadData),
        .memRead      (memRead),
        .memWrite     (memWrite),
        .memAddr      (memAddr),
        .memWriteData (memWriteData),
        .acc          (acc),
        .link         (link),
        .pc           (pc),
        .halted       (halted)
    );

    bind pdp8_core pdp8_assertions assertions (
        .clk      (clk),
        .reset_n  (reset_n),
        .memRead  (memRead),
        .memWrite (memWrite),
        .halted   (halted)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic checkAddr(input string name, input pdp8_pkg::addrWord expected,
                             input pdp8_pkg::addrWord actual);
        if (actual !== expected) begin
            abortRun($sformatf("ERROR %s expected %04o actual %04o", name, expected, actual));
        end
    endtask

    task automatic checkData(input string name, input pdp8_pkg::dataWord expected,
                             input pdp8_pkg::dataWord actual);
        if (actual !== expected) begin
            abortRun($sformatf("ERROR %s expected %04o actual %04o", name, expected, actual));
        end
    endtask

    task automatic checkBit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            abortRun($sformatf("ERROR %s expected %b actual %b", name, expected, actual));
        end
    endtask

    // Memory answers one cycle after the read strobe
    always @(posedge clk) begin
        if (memRead) begin
            memReadData <= mem[memAddr];
        end
        if (memWrite) begin
            mem[memAddr] <= memWriteData;
        end
    end

    // Every write is compared in order with the next expected one
    always @(negedge clk) begin
        if (reset_n && memWrite) begin
            if (expAddr.size() == 0) begin
                abortRun($sformatf("unexpected memory write to address %04o", memAddr));
            end else begin
                checkAddr($sformatf("write %0d address", writeCount), expAddr.pop_front(),
                          memAddr);
                checkData($sformatf("write %0d data", writeCount), expData.pop_front(),
                          memWriteData);
                writeCount++;
            end
        end
    end

    always @(negedge clk) begin
        if (dut.assertions.failCount != 0) begin
            abortRun("a concurrent assertion on the memory port or halt flag failed");
        end
    end

    task automatic loadTestData();
        int          fd;
        int          ch;
        int          fields;
        int          i;
        logic [31:0] fieldA;
        logic [31:0] fieldB;
        logic [31:0] fieldC;

        // Fill of unlisted words follows the full address
        for (i = 0; i < (1 << `ADDR_WIDTH); i++) begin
            mem[i] = ~i[`DATA_WIDTH-1:0];
        end
        fd = $fopen("pdp8_testdata.txt", "r");
        if (fd == 0) begin
            abortRun("cannot open the test data file pdp8_testdata.txt");
        end
        ch = $fgetc(fd);
        while (ch != -1) begin
            if (ch == "#") begin
                while (ch != -1 && ch != "\n") begin
                    ch = $fgetc(fd);
                end
            end else if (ch == "M" || ch == "W") begin
                fields = $fscanf(fd, "%o %o", fieldA, fieldB);
                if (fields != 2) begin
                    abortRun("a memory line of the test data file is malformed");
                end
                if (ch == "M") begin
                    mem[fieldA[`ADDR_WIDTH-1:0]] = fieldB[`DATA_WIDTH-1:0];
                end else begin
                    expAddr.push_back(fieldA[`ADDR_WIDTH-1:0]);
                    expData.push_back(fieldB[`DATA_WIDTH-1:0]);
                end
            end else if (ch == "E") begin
                fields = $fscanf(fd, "%o %o %o", fieldA, fieldB, fieldC);
                if (fields != 3) begin
                    abortRun("the final state line of the test data file is malformed");
                end
                finalAcc  = fieldA[`DATA_WIDTH-1:0];
                finalLink = fieldB[0];
                finalPc   = fieldC[`ADDR_WIDTH-1:0];
                haveFinal = 1'b1;
            end else if (ch != " " && ch != "\n" && ch != "\r" && ch != "\t") begin
                abortRun("the test data file holds a line of unknown kind");
            end
            if (ch != -1) begin
                ch = $fgetc(fd);
            end
        end
        $fclose(fd);
        if (!haveFinal) begin
            abortRun("the test data file gives no final state");
        end
    endtask

    task automatic waitFirstFetch();
        int cycles;

        cycles = 0;
        @(negedge clk);
        while (memRead !== 1'b1 && cycles < fetchTimeout) begin
            @(negedge clk);
            cycles++;
        end
        if (memRead !== 1'b1) begin
            abortRun("no fetch strobe came within the timeout after reset");
        end
        checkAddr("first fetch address", `START_ADDRESS, memAddr);
    endtask

    task automatic waitHalt();
        int cycles;

        cycles = 0;
        @(negedge clk);
        while (halted !== 1'b1 && cycles < haltTimeout) begin
            @(negedge clk);
            cycles++;
        end
        if (halted !== 1'b1) begin
            abortRun("the core did not halt within the timeout");
        end
    endtask

    // No memory traffic once halted
    task automatic watchQuiet();
        repeat (quietCycles) begin
            @(negedge clk);
            checkBit("memRead after halt", 1'b0, memRead);
            checkBit("memWrite after halt", 1'b0, memWrite);
            checkBit("halted after halt", 1'b1, halted);
        end
    endtask

    initial begin
        int cycle;

        reset_n = 1'b0;
        loadTestData();
        for (cycle = 1; cycle < resetCycles; cycle++) begin
            @(negedge clk);
            checkBit("memRead in reset", 1'b0, memRead);
            checkBit("memWrite in reset", 1'b0, memWrite);
            checkBit("halted in reset", 1'b0, halted);
            checkAddr("pc in reset", `START_ADDRESS, pc);
            checkData("acc in reset", '0, acc);
            checkBit("link in reset", 1'b0, link);
        end
        @(posedge clk);
        reset_n <= 1'b1;

        waitFirstFetch();
        waitHalt();
        checkData("final acc", finalAcc, acc);
        checkBit("final link", finalLink, link);
        checkAddr("final pc", finalPc, pc);
        watchQuiet();

        if (expAddr.size() == 0 && dut.assertions.failCount == 0) begin
            $display(">>> PASS");
            $finish;
        end else if (expAddr.size() != 0) begin
            abortRun($sformatf("%0d expected memory writes never happened", expAddr.size()));
        end else begin
            abortRun("a concurrent assertion on the memory port or halt flag failed");
        end
    end

endmodule

`default_nettype wire

//--- pdp8_assertions.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Concurrent checks on memory strobes and halt flag bound into the core
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module pdp8_assertions (
    input logic clk,
    input logic reset_n,
    input logic memRead,
    input logic memWrite,
    input logic halted
);

    // Number of failed assertions so far
    int failCount = 0;

    // One memory access per cycle
    property singleStrobe;
        @(posedge clk) disable iff (!reset_n)
            !(memRead && memWrite);
    endproperty

    property quietWhileHalted;
        @(posedge clk) disable iff (!reset_n)
            halted |-> (!memRead && !memWrite);
    endproperty

    // Only a reset clears the halt flag
    property haltSticky;
        @(posedge clk) disable iff (!reset_n)
            halted |=> halted;
    endproperty

    singleStrobeCheck: assert property (singleStrobe) else begin
        $error("memRead and memWrite are high in the same cycle");
        failCount++;
    end

    quietWhileHaltedCheck: assert property (quietWhileHalted) else begin
        $error("memory strobe while the core is halted");
        failCount++;
    end

    haltStickyCheck: assert property (haltSticky) else begin
        $error("halted fell without a reset");
        failCount++;
    end

endmodule

`default_nettype wire

//--- pdp8_core.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PDP-8 execution core top level with a single external memory port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module pdp8_core (
    input  logic              clk,
    input  logic              reset_n,
    input  pdp8_pkg::dataWord memReadData,
    output logic              memRead,
    output logic              memWrite,
    output pdp8_pkg::addrWord memAddr,
    output pdp8_pkg::dataWord memWriteData,
    output pdp8_pkg::dataWord acc,
    output logic              link,
    output pdp8_pkg::addrWord pc,
    output logic              halted
);

    pdp8_pkg::instrWord instr;
    pdp8_pkg::memOp     op;
    pdp8_pkg::dataWord  operand;
    pdp8_pkg::dataWord  aluAcc;
    logic               aluLink;
    pdp8_pkg::dataWord  aluWriteData;
    logic               aluSkip;
    pdp8_pkg::dataWord  oprAcc;
    logic               oprLink;
    logic               oprSkip;
    logic               oprHalt;

    pdp8_sequencer sequencer (
        .clk          (clk),
        .reset_n      (reset_n),
        .memReadData  (memReadData),
        .aluAcc       (aluAcc),
        .aluLink      (aluLink),
        .aluWriteData (aluWriteData),
        .aluSkip      (aluSkip),
        .oprAcc       (oprAcc),
        .oprLink      (oprLink),
        .oprSkip      (oprSkip),
        .oprHalt      (oprHalt),
        .memRead      (memRead),
        .memWrite     (memWrite),
        .memAddr      (memAddr),
        .memWriteData (memWriteData),
        .instr        (instr),
        .op           (op),
        .acc          (acc),
        .link         (link),
        .operand      (operand),
        .pc           (pc),
        .halted       (halted)
    );

    pdp8_alu alu (
        .op        (op),
        .acc       (acc),
        .link      (link),
        .operand   (operand),
        .nextAcc   (aluAcc),
        .nextLink  (aluLink),
        .writeData (aluWriteData),
        .skip      (aluSkip)
    );

    pdp8_operate operate (
        .instr    (instr),
        .acc      (acc),
        .link     (link),
        .nextAcc  (oprAcc),
        .nextLink (oprLink),
        .skip     (oprSkip),
        .halt     (oprHalt)
    );

endmodule

`default_nettype wire

//--- pdp8_sequencer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction FSM holding PC, AC and link, and driving the memory port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "pdp8_settings.svh"

module pdp8_sequencer (
    input  logic               clk,
    input  logic               reset_n,
    input  pdp8_pkg::dataWord  memReadData,
    input  pdp8_pkg::dataWord  aluAcc,
    input  logic               aluLink,
    input  pdp8_pkg::dataWord  aluWriteData,
    input  logic               aluSkip,
    input  pdp8_pkg::dataWord  oprAcc,
    input  logic               oprLink,
    input  logic               oprSkip,
    input  logic               oprHalt,
    output logic               memRead,
    output logic               memWrite,
    output pdp8_pkg::addrWord  memAddr,
    output pdp8_pkg::dataWord  memWriteData,
    output pdp8_pkg::instrWord instr,
    output pdp8_pkg::memOp     op,
    output pdp8_pkg::dataWord  acc,
    output logic               link,
    output pdp8_pkg::dataWord  operand,
    output pdp8_pkg::addrWord  pc,
    output logic               halted
);

    localparam logic [2:0] stIdle    = 3'd0;
    localparam logic [2:0] stFetch   = 3'd1;
    localparam logic [2:0] stDecode  = 3'd2;
    localparam logic [2:0] stRead    = 3'd3;
    localparam logic [2:0] stExecute = 3'd4;
    localparam logic [2:0] stWrite   = 3'd5;
    localparam logic [2:0] stOperate = 3'd6;

    logic [2:0]         state;
    pdp8_pkg::instrWord fetched;
    pdp8_pkg::addrWord  decodedAddr;
    pdp8_pkg::addrWord  effAddr;
    pdp8_pkg::dataWord  operandReg;
    pdp8_pkg::addrWord  pcPlusOne;
    pdp8_pkg::addrWord  pcPlusTwo;

    assign fetched   = memReadData;
    assign pcPlusOne = pc + 1'b1;
    assign pcPlusTwo = pc + 2'd2;
    assign op        = instr.memRef.opcode;

    // Page zero or the page of the instruction itself
    assign decodedAddr = fetched.memRef.pageSelect ?
        {pc[`ADDR_WIDTH-1:`PAGE_BITS], fetched.memRef.offset} :
        {{(`ADDR_WIDTH-`PAGE_BITS){1'b0}}, fetched.memRef.offset};

    // Read data goes straight to the ALU in X and is held for the ISZ write
    assign operand = (state == stExecute) ? memReadData : operandReg;

    // Memory port strobes decode the current state
    assign memRead      = (state == stFetch) || (state == stRead);
    assign memWrite     = (state == stWrite);
    assign memAddr      = (state == stFetch) ? pc : effAddr;
    assign memWriteData = (op == pdp8_pkg::opJms) ? pcPlusOne : aluWriteData;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state  <= stIdle;
            pc     <= `START_ADDRESS;
            acc    <= '0;
            link   <= 1'b0;
            halted <= 1'b0;
        end else begin
            case (state)
                stIdle: begin
                    // Held here after a halt until the next reset
                    if (!halted) begin
                        state <= stFetch;
                    end
                end
                stFetch: begin
                    state <= stDecode;
                end
                stDecode: begin
                    case (fetched.memRef.opcode)
                        pdp8_pkg::opJmp: begin
                            pc    <= decodedAddr;
                            state <= stFetch;
                        end
                        pdp8_pkg::opAnd, pdp8_pkg::opTad, pdp8_pkg::opIsz: begin
                            state <= stRead;
                        end
                        pdp8_pkg::opDca, pdp8_pkg::opJms: begin
                            state <= stWrite;
                        end
                        default: begin
                            state <= stOperate;
                        end
                    endcase
                end
                stRead: begin
                    state <= stExecute;
                end
                stExecute: begin
                    if (op == pdp8_pkg::opIsz) begin
                        state <= stWrite;
                    end else begin
                        acc   <= aluAcc;
                        link  <= aluLink;
                        pc    <= pcPlusOne;
                        state <= stFetch;
                    end
                end
                stWrite: begin
                    case (op)
                        pdp8_pkg::opJms: pc <= effAddr + 1'b1;
                        pdp8_pkg::opIsz: pc <= aluSkip ? pcPlusTwo : pcPlusOne;
                        default: begin
                            acc <= aluAcc;
                            pc  <= pcPlusOne;
                        end
                    endcase
                    state <= stFetch;
                end
                stOperate: begin
                    acc  <= oprAcc;
                    link <= oprLink;
                    pc   <= oprSkip ? pcPlusTwo : pcPlusOne;
                    if (oprHalt) begin
                        halted <= 1'b1;
                        state  <= stIdle;
                    end else begin
                        state <= stFetch;
                    end
                end
                default: begin
                    state <= stIdle;
                end
            endcase
        end
    end

    // Instruction, target address and ISZ operand
    always_ff @(posedge clk) begin
        if (state == stDecode) begin
            instr   <= fetched;
            effAddr <= decodedAddr;
        end
        if (state == stExecute) begin
            operandReg <= memReadData;
        end
    end

endmodule

`default_nettype wire

//--- pdp8_operate.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Group 1 and group 2 operate micro-ops, with skip and halt decisions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "pdp8_settings.svh"

module pdp8_operate (
    input  pdp8_pkg::instrWord instr,
    input  pdp8_pkg::dataWord  acc,
    input  logic               link,
    output pdp8_pkg::dataWord  nextAcc,
    output logic               nextLink,
    output logic               skip,
    output logic               halt
);

    pdp8_pkg::group1Bits g1;
    pdp8_pkg::group2Bits g2;
    logic                isOperate;
    logic                isGroup1;
    logic                isGroup2;
    logic                anyTest;

    assign g1        = instr.grp1.micro;
    assign g2        = instr.grp2.micro;
    assign isOperate = (instr.grp1.opcode == pdp8_pkg::opOpr);
    assign isGroup1  = isOperate && !instr.grp1.group;
    // Low bit set would be group 3, which is a no-op here
    assign isGroup2  = isOperate && instr.grp2.group && !g2.spare;

    // Selected skip tests ORed together
    assign anyTest = (g2.sma && acc[`DATA_WIDTH-1]) ||
                     (g2.sza && (acc == '0)) ||
                     (g2.snl && link);

    always_comb begin
        nextAcc  = acc;
        nextLink = link;
        skip     = 1'b0;
        halt     = 1'b0;

        if (isGroup1) begin
            if (g1.cla) begin
                nextAcc = '0;
            end
            if (g1.cll) begin
                nextLink = 1'b0;
            end
            if (g1.cma) begin
                nextAcc = ~nextAcc;
            end
            if (g1.cml) begin
                nextLink = ~nextLink;
            end
            if (g1.iac) begin
                {nextLink, nextAcc} = {nextLink, nextAcc} + 1'b1;
            end
            // Rotates run through the link, twice with BSW
            if (g1.ral) begin
                {nextLink, nextAcc} = {nextAcc, nextLink};
                if (g1.bsw) begin
                    {nextLink, nextAcc} = {nextAcc, nextLink};
                end
            end else if (g1.rar) begin
                {nextLink, nextAcc} = {nextAcc[0], nextLink, nextAcc[`DATA_WIDTH-1:1]};
                if (g1.bsw) begin
                    {nextLink, nextAcc} = {nextAcc[0], nextLink, nextAcc[`DATA_WIDTH-1:1]};
                end
            end
        end else if (isGroup2) begin
            // Reverse turns the OR into the AND of the negated tests
            skip = anyTest ^ g2.reverse;
            if (g2.cla) begin
                nextAcc = '0;
            end
            halt = g2.hlt;
        end
    end

endmodule

`default_nettype wire

//--- pdp8_alu.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory-reference arithmetic, sampled by the sequencer in X and W
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module pdp8_alu (
    input  pdp8_pkg::memOp    op,
    input  pdp8_pkg::dataWord acc,
    input  logic              link,
    input  pdp8_pkg::dataWord operand,
    output pdp8_pkg::dataWord nextAcc,
    output logic              nextLink,
    output pdp8_pkg::dataWord writeData,
    output logic              skip
);

    pdp8_pkg::dataWord incremented;

    assign incremented = operand + 1'b1;

    always_comb begin
        // Unchanged state unless the opcode says otherwise
        nextAcc   = acc;
        nextLink  = link;
        writeData = acc;
        skip      = 1'b0;

        case (op)
            pdp8_pkg::opAnd: begin
                nextAcc = acc & operand;
            end
            pdp8_pkg::opTad: begin
                // Carry out of the word complements the link
                {nextLink, nextAcc} = {link, acc} + {1'b0, operand};
            end
            pdp8_pkg::opIsz: begin
                writeData = incremented;
                skip      = (incremented == '0);
            end
            pdp8_pkg::opDca: begin
                // Store AC, then clear it
                nextAcc = '0;
            end
            default: begin
                nextAcc = acc;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- pdp8_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Word types and instruction decode views shared by the PDP-8 core
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "pdp8_settings.svh"

package pdp8_pkg;

    typedef logic [`ADDR_WIDTH-1:0] addrWord;
    typedef logic [`DATA_WIDTH-1:0] dataWord;

    // Major opcode in instruction bits 11:9
    typedef enum logic [2:0] {
        opAnd = 3'o0,
        opTad = 3'o1,
        opIsz = 3'o2,
        opDca = 3'o3,
        opJms = 3'o4,
        opJmp = 3'o5,
        opIot = 3'o6,
        opOpr = 3'o7
    } memOp;

    // Micro-op bits, listed MSB first as on the front panel
    typedef struct packed {
        logic cla, cll, cma, cml, rar, ral, bsw, iac;
    } group1Bits;

    typedef struct packed {
        logic cla, sma, sza, snl, reverse, osr, hlt, spare;
    } group2Bits;

    // pageSelect low means page zero
    typedef struct packed {
        memOp                  opcode;
        logic                  indirect;
        logic                  pageSelect;
        logic [`PAGE_BITS-1:0] offset;
    } memRefView;

    typedef struct packed {
        memOp      opcode;
        logic      group;
        group1Bits micro;
    } group1View;

    typedef struct packed {
        memOp      opcode;
        logic      group;
        group2Bits micro;
    } group2View;

    typedef union packed {
        memRefView memRef;
        group1View grp1;
        group2View grp2;
    } instrWord;

endpackage

`default_nettype wire

//--- pdp8_settings.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Width and reset address macros for the PDP-8 core and its testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef PDP8_SETTINGS_SVH
`define PDP8_SETTINGS_SVH

// Memory address and word widths
`define ADDR_WIDTH 12
`define DATA_WIDTH 12

// Offset bits inside one 128-word page
`define PAGE_BITS 7

// First fetch address after reset
`define START_ADDRESS 12'o200

`endif
